//--- source/cache_geom_pkg.sv
package cache_geom_pkg;

	// byte address, 16-bit words
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// 256 lines of four words
	localparam int INDEX_W = 8;
	localparam int WORD_SEL_W = 2;
	localparam int TAG_W = ADDR_W - INDEX_W - WORD_SEL_W - 1;
	localparam int LINE_WORDS = 2 ** WORD_SEL_W;
	localparam int NUM_LINES = 2 ** INDEX_W;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [WORD_SEL_W-1:0] word_sel_t;
	typedef logic [DATA_W-1:0] word_t;

	// fields of a CPU byte address, msb first
	typedef struct packed {
		tag_t tag;
		index_t index;
		word_sel_t word;
		logic byte_sel;
	} addr_split_t;

endpackage

//--- source/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	import cache_geom_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		COMPARE,
		EVICT_REQ,
		EVICT_WAIT,
		FILL_REQ,
		FILL_WAIT,
		FILL_WRITE,
		FINISH
	} ctrl_state_e;

	typedef enum logic [1:0] {
		CACHE_LOOKUP = 2'd0,
		CACHE_STORE_HIT = 2'd1,
		CACHE_LINE_READ = 2'd2,
		CACHE_FILL = 2'd3
	} cache_op_e;

	// controller to cache store
	typedef struct packed {
		logic en;
		cache_op_e op;
		tag_t tag;
		index_t index;
		word_sel_t word;
		word_t wdata;
		logic last;
	} cache_cmd_t;

	typedef struct packed {
		logic hit;
		logic dirty;
		tag_t tag;
		word_t rdata;
	} cache_rsp_t;

	// one word per memory transaction
	typedef struct packed {
		logic strobe;
		logic write;
		logic [ADDR_W-1:0] addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic busy;
		logic rvalid;
		word_t rdata;
	} mem_rsp_t;

endpackage

//--- source/cache_controller.sv
`timescale 1ns/1ps

module cache_controller
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [ADDR_W-1:0] addr,
	input word_t data_in,
	input logic rd,
	input logic wr,
	input cache_rsp_t store_rsp,
	input mem_rsp_t mem_rsp,
	output word_t data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err,
	output cache_cmd_t store_cmd,
	output mem_req_t mem_req
);

	localparam word_sel_t LAST_WORD = word_sel_t'(LINE_WORDS - 1);

	// request held from acceptance until done
	typedef struct packed {
		addr_split_t addr;
		word_t wdata;
		logic read;
		logic write;
		logic illegal;
		logic hit;
	} req_t;

	ctrl_state_e state;
	ctrl_state_e state_n;
	word_sel_t cnt;
	word_sel_t cnt_n;
	req_t req_q;
	addr_split_t addr_in;
	word_t fill_q;
	word_t rdata_q;
	logic accept;
	logic ret_read;

	assign addr_in = addr;
	assign accept = (state == IDLE) && (rd || wr);
	assign stall = (state != IDLE);
	assign ret_read = done && req_q.read && !req_q.illegal;
	assign data_out = ret_read ? store_rsp.rdata : rdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			cnt <= '0;
			req_q <= '0;
		end else begin
			state <= state_n;
			cnt <= cnt_n;
			if (accept) begin
				req_q.addr <= addr_in;
				req_q.wdata <= data_in;
				req_q.read <= rd;
				req_q.write <= wr;
				req_q.illegal <= addr_in.byte_sel || (rd && wr);
				// lookup in IDLE already ran on the incoming address
				req_q.hit <= store_rsp.hit;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_rsp.rvalid) begin
			fill_q <= mem_rsp.rdata;
		end
		if (ret_read) begin
			rdata_q <= store_rsp.rdata;
		end
	end

	// next state, counter and CPU status
	always_comb begin
		state_n = state;
		cnt_n = cnt;
		done = 1'b0;
		err = 1'b0;
		cache_hit = 1'b0;
		case (state)
			IDLE: begin
				if (accept) begin
					state_n = COMPARE;
				end
			end
			COMPARE: begin
				cnt_n = '0;
				if (req_q.illegal) begin
					done = 1'b1;
					err = 1'b1;
					state_n = IDLE;
				end else if (store_rsp.hit) begin
					done = 1'b1;
					cache_hit = 1'b1;
					state_n = IDLE;
				end else if (store_rsp.dirty) begin
					state_n = EVICT_REQ;
				end else begin
					state_n = FILL_REQ;
				end
			end
			EVICT_REQ: state_n = EVICT_WAIT;
			EVICT_WAIT: begin
				if (!mem_rsp.busy) begin
					// counter wraps to word 0 for the fill
					cnt_n = cnt + 1'b1;
					state_n = (cnt == LAST_WORD) ? FILL_REQ : EVICT_REQ;
				end
			end
			FILL_REQ: state_n = FILL_WAIT;
			FILL_WAIT: begin
				if (mem_rsp.rvalid) begin
					state_n = FILL_WRITE;
				end
			end
			FILL_WRITE: begin
				cnt_n = cnt + 1'b1;
				state_n = (cnt == LAST_WORD) ? FINISH : FILL_REQ;
			end
			FINISH: begin
				done = 1'b1;
				state_n = IDLE;
			end
			default: state_n = IDLE;
		endcase
	end

	// store command, driven from registers and CPU inputs only
	always_comb begin
		store_cmd = '0;
		store_cmd.tag = req_q.addr.tag;
		store_cmd.index = req_q.addr.index;
		store_cmd.word = req_q.addr.word;
		store_cmd.wdata = req_q.wdata;
		case (state)
			IDLE: begin
				store_cmd.en = rd || wr;
				store_cmd.op = CACHE_LOOKUP;
				store_cmd.tag = addr_in.tag;
				store_cmd.index = addr_in.index;
				store_cmd.word = addr_in.word;
			end
			COMPARE: begin
				store_cmd.en = !req_q.illegal;
				store_cmd.op = (req_q.write && req_q.hit) ? CACHE_STORE_HIT : CACHE_LOOKUP;
			end
			EVICT_REQ: begin
				store_cmd.en = 1'b1;
				store_cmd.op = CACHE_LINE_READ;
				store_cmd.word = cnt;
			end
			FILL_WRITE: begin
				store_cmd.en = 1'b1;
				store_cmd.op = CACHE_FILL;
				store_cmd.word = cnt;
				store_cmd.wdata = fill_q;
				store_cmd.last = (cnt == LAST_WORD);
			end
			FINISH: begin
				// line is resident now, replay as a hit
				store_cmd.en = 1'b1;
				store_cmd.op = req_q.write ? CACHE_STORE_HIT : CACHE_LOOKUP;
			end
			default: ;
		endcase
	end

	always_comb begin
		mem_req = '0;
		case (state)
			EVICT_REQ: begin
				// victim word comes straight from the line read
				mem_req.strobe = 1'b1;
				mem_req.write = 1'b1;
				mem_req.addr = {store_rsp.tag, req_q.addr.index, cnt, 1'b0};
				mem_req.wdata = store_rsp.rdata;
			end
			FILL_REQ: begin
				mem_req.strobe = 1'b1;
				mem_req.addr = {req_q.addr.tag, req_q.addr.index, cnt, 1'b0};
			end
			default: ;
		endcase
	end

	// request states are only reached once memory has gone idle
	a_strobe_idle: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.strobe |-> !mem_rsp.busy);

	// a request only ends with no memory transaction in flight
	a_done_state: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (state != IDLE) && !mem_rsp.busy);

endmodule

//--- source/cache_store.sv
`timescale 1ns/1ps

module cache_store
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input cache_cmd_t cmd,
	output cache_rsp_t rsp
);

	tag_t tag_mem [NUM_LINES];
	word_t data_mem [NUM_LINES*LINE_WORDS];
	logic [NUM_LINES-1:0] valid;
	logic [NUM_LINES-1:0] dirty;
	logic [INDEX_W+WORD_SEL_W-1:0] waddr;
	logic line_hit;
	logic store_hit;
	logic fill;
	logic fill_last;

	assign waddr = {cmd.index, cmd.word};
	assign line_hit = valid[cmd.index] && (tag_mem[cmd.index] == cmd.tag);

	// write only lands when the compare matches
	assign store_hit = cmd.en && (cmd.op == CACHE_STORE_HIT) && line_hit;
	assign fill = cmd.en && (cmd.op == CACHE_FILL);
	assign fill_last = fill && cmd.last;

	always_comb begin
		rsp.hit = line_hit;
		rsp.dirty = dirty[cmd.index];
		rsp.tag = tag_mem[cmd.index];
		rsp.rdata = data_mem[waddr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			if (store_hit) begin
				dirty[cmd.index] <= 1'b1;
			end
			// last fill word makes the line resident and clean
			if (fill_last) begin
				valid[cmd.index] <= 1'b1;
				dirty[cmd.index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (store_hit || fill) begin
			data_mem[waddr] <= cmd.wdata;
		end
		if (fill_last) begin
			tag_mem[cmd.index] <= cmd.tag;
		end
	end

	// controller's early lookup must agree with the compare cycle
	a_store_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd.en && cmd.op == CACHE_STORE_HIT) |-> rsp.hit);

endmodule

//--- source/main_memory.sv
`timescale 1ns/1ps

module main_memory
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;
#(
	parameter int MEM_LATENCY = 4
) (
	input logic clk,
	input logic rst_n,
	input mem_req_t req,
	output mem_rsp_t rsp
);

	localparam int MEM_WORDS = 2 ** (ADDR_W - 1);
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	word_t mem [MEM_WORDS];
	logic [MEM_WORDS-1:0] written;
	logic [ADDR_W-2:0] widx;
	logic [CNT_W-1:0] lat_cnt;
	logic rd_pend;
	logic busy;
	logic accept;
	word_t rdata_q;

	assign widx = req.addr[ADDR_W-1:1];
	assign busy = (lat_cnt != '0);
	assign accept = req.strobe && !busy;

	always_comb begin
		rsp.busy = busy;
		// read data shows in the last busy cycle
		rsp.rvalid = rd_pend && (lat_cnt == CNT_W'(1));
		rsp.rdata = rdata_q;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lat_cnt <= '0;
			rd_pend <= 1'b0;
			written <= '0;
		end else if (accept) begin
			lat_cnt <= CNT_W'(MEM_LATENCY);
			rd_pend <= !req.write;
			if (req.write) begin
				written[widx] <= 1'b1;
			end
		end else if (busy) begin
			lat_cnt <= lat_cnt - 1'b1;
		end
	end

	// untouched words read back as their own byte address
	always_ff @(posedge clk) begin
		if (accept && req.write) begin
			mem[widx] <= req.wdata;
		end
		if (accept && !req.write) begin
			rdata_q <= written[widx] ? mem[widx] : {widx, 1'b0};
		end
	end

	a_no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
		req.strobe |-> !busy);

endmodule

//--- source/cache_system.sv
`timescale 1ns/1ps

module cache_system
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;
#(
	parameter int MEM_LATENCY = 4
) (
	input logic clk,
	input logic rst_n,
	input logic [ADDR_W-1:0] addr,
	input word_t data_in,
	input logic rd,
	input logic wr,
	output word_t data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err
);

	cache_cmd_t store_cmd;
	cache_rsp_t store_rsp;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	cache_controller u_controller (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.store_rsp(store_rsp),
		.mem_rsp(mem_rsp),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err),
		.store_cmd(store_cmd),
		.mem_req(mem_req)
	);

	cache_store u_store (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(store_cmd),
		.rsp(store_rsp)
	);

	main_memory #(
		.MEM_LATENCY(MEM_LATENCY)
	) u_memory (
		.clk(clk),
		.rst_n(rst_n),
		.req(mem_req),
		.rsp(mem_rsp)
	);

endmodule

//--- verification/cache_ref_model.svh
`ifndef CACHE_REF_MODEL_SVH
`define CACHE_REF_MODEL_SVH

// cpu view of memory, writes applied in order
word_t mem_img [2 ** (ADDR_W - 1)];

// direct-mapped tag table
tag_t tag_tab [NUM_LINES];
logic valid_tab [NUM_LINES];

function automatic void reset_model();
	// untouched words hold their own byte address
	for (int i = 0; i < 2 ** (ADDR_W - 1); i++) begin
		mem_img[i] = word_t'(i * 2);
	end
	for (int i = 0; i < NUM_LINES; i++) begin
		valid_tab[i] = 1'b0;
		tag_tab[i] = '0;
	end
endfunction

function automatic logic predict_hit(input logic [ADDR_W-1:0] a);
	addr_split_t f;
	f = a;
	return valid_tab[f.index] && (tag_tab[f.index] == f.tag);
endfunction

function automatic word_t read_model(input logic [ADDR_W-1:0] a);
	return mem_img[a[ADDR_W-1:1]];
endfunction

function automatic void write_model(input logic [ADDR_W-1:0] a, input word_t d);
	mem_img[a[ADDR_W-1:1]] = d;
endfunction

// a legal access leaves its line resident
function automatic void touch_line(input logic [ADDR_W-1:0] a);
	addr_split_t f;
	f = a;
	valid_tab[f.index] = 1'b1;
	tag_tab[f.index] = f.tag;
endfunction

`endif

//--- verification/cache_system_tb.sv
`timescale 1ns/1ps

module cache_system_tb
	import cache_geom_pkg::*;
();

	localparam int MEM_LATENCY = 4;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_OPS = 300;
	// random traffic plus the directed accesses
	localparam int NUM_OPS = RANDOM_OPS + 9;
	localparam int OP_CYCLES = 8 * (MEM_LATENCY + 3) + 6;
	localparam logic [31:0] SEED = 32'hea177eaa;

	logic clk;
	logic rst_n;
	logic [ADDR_W-1:0] addr;
	word_t data_in;
	logic rd;
	logic wr;
	word_t data_out;
	logic done;
	logic stall;
	logic cache_hit;
	logic err;

	int errors;
	int checks;
	int tests_run;
	int test_start_errors;

	`include "cache_ref_model.svh"

	cache_system #(
		.MEM_LATENCY(MEM_LATENCY)
	) u_cache_system (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// worst case is a dirty miss on every access
	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + NUM_OPS * OP_CYCLES));
		$display("Timeout: the DUT did not finish all accesses in the allowed time");
		$display("Test failed");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error at %0d ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("%-20s %s (%0d mismatches)", name,
			(errors == test_start_errors) ? "ok" : "FAIL", errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// one CPU request, checked against the model when done arrives
	task automatic access(input logic do_rd, input logic do_wr,
		input logic [ADDR_W-1:0] a, input word_t d);
		logic legal;
		logic exp_hit;
		word_t exp_data;
		int cycles;
		legal = !a[0] && !(do_rd && do_wr);
		exp_hit = legal && predict_hit(a);
		exp_data = read_model(a);
		@(posedge clk);
		addr <= a;
		data_in <= d;
		rd <= do_rd;
		wr <= do_wr;
		// previous request is over, done was a single pulse
		@(negedge clk);
		check("done", 32'd0, 32'(done));
		check("stall", 32'd0, 32'(stall));
		// accepted on this edge
		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			check("stall", 32'd1, 32'(stall));
		end while (!done);
		check("err", 32'(!legal), 32'(err));
		check("cache_hit", 32'(exp_hit), 32'(cache_hit));
		if (!legal || exp_hit) begin
			check("done latency", 32'd1, cycles);
		end
		if (legal && do_rd) begin
			check("data_out", 32'(exp_data), 32'(data_out));
		end
		if (legal) begin
			if (do_wr) begin
				write_model(a, d);
			end
			touch_line(a);
		end
	endtask

	initial begin
		tag_t t;
		index_t idx;
		word_sel_t w;
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-1:0] b;
		errors = 0;
		checks = 0;
		tests_run = 0;
		test_start_errors = 0;
		void'($urandom(SEED));
		rst_n = 1'b0;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		check("stall", 32'd0, 32'(stall));
		check("done", 32'd0, 32'(done));
		check("err", 32'd0, 32'(err));
		access(1'b1, 1'b0, 16'h1234, '0);
		check("cache_hit", 32'd0, 32'(cache_hit));
		check("data_out", 32'h1234, 32'(data_out));
		report_test("reset state");

		// few tags over few indices forces conflicts
		for (int i = 0; i < RANDOM_OPS; i++) begin
			t = tag_t'($urandom_range(3, 0));
			idx = index_t'(40 + $urandom_range(3, 0));
			w = word_sel_t'($urandom_range(3, 0));
			a = {t, idx, w, 1'b0};
			if ($urandom_range(1, 0) == 1) begin
				access(1'b0, 1'b1, a, word_t'($urandom));
			end else begin
				access(1'b1, 1'b0, a, '0);
			end
		end
		report_test("random traffic");

		a = {tag_t'(2), index_t'(99), word_sel_t'(1), 1'b0};
		b = {tag_t'(7), index_t'(99), word_sel_t'(1), 1'b0};
		access(1'b0, 1'b1, a, 16'hbeef);
		access(1'b1, 1'b0, b, '0);
		access(1'b1, 1'b0, a, '0);
		check("data_out", 32'hbeef, 32'(data_out));
		report_test("dirty eviction");

		a = {tag_t'(1), index_t'(40), word_sel_t'(2), 1'b1};
		access(1'b1, 1'b0, a, '0);
		a = {tag_t'(1), index_t'(40), word_sel_t'(2), 1'b0};
		access(1'b1, 1'b1, a, 16'h5a5a);
		access(1'b1, 1'b0, a, '0);
		report_test("illegal requests");

		a = {tag_t'(3), index_t'(120), word_sel_t'(0), 1'b0};
		access(1'b1, 1'b0, a, '0);
		a = {tag_t'(3), index_t'(120), word_sel_t'(3), 1'b0};
		access(1'b1, 1'b0, a, '0);
		check("cache_hit", 32'd1, 32'(cache_hit));
		report_test("hit latency");

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+verification
source/cache_geom_pkg.sv
source/cache_ctrl_pkg.sv
source/cache_controller.sv
source/cache_store.sv
source/main_memory.sv
source/cache_system.sv
verification/cache_system_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cache_system_tb
RTL_TOP ?= cache_system
FILELIST ?= src.f
FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "simulation ended early"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
